// ==== test/id_testdata.txt ====
// instr pc flush fu funct3 rd rs1 rs2 imm ctrl_flow illegal compressed
// All values hex, flush=1 records are flushed and never delivered
FFD30293 00001000 0 1 0 05 06 00 FFFFFFFD 0 0 0
40C58533 00001004 0 1 0 0A 0B 0C 00000000 0 0 0
123457B7 00001008 0 1 0 0F 00 00 12345000 0 0 0
FF1FF0EF 0000100C 0 2 0 01 00 00 FFFFFFF0 1 0 0
00C302E7 00001010 0 2 0 05 06 00 0000000C 1 0 0
0080006F 00001014 1 2 0 00 00 00 00000008 1 0 0
FE209CE3 00001018 0 2 1 00 01 02 FFFFFFF8 1 0 0
0044A403 0000101C 0 3 2 08 09 00 00000004 0 0 0
00512423 00001020 0 4 2 00 02 05 00000008 0 0 0
0FF0000F 00001024 0 0 0 00 00 00 00000000 0 1 0
0000157D 00001028 0 1 0 0A 0A 00 FFFFFFFF 0 0 1
00004595 0000102A 0 1 0 0B 00 00 00000005 0 0 1
00008636 0000102C 0 1 0 0C 00 0D 00000000 0 0 1
009443B3 0000102E 1 1 4 07 08 09 00000000 0 0 0
0000973E 00001032 0 1 0 0E 0E 0F 00000000 0 0 1
0000A805 00001034 0 2 0 00 00 00 00000030 1 0 1
00004164 00001036 0 3 2 09 0A 00 00000044 0 0 1
0000DC5C 00001038 0 4 2 00 08 0F 0000003C 0 0 1
00000000 0000103A 0 0 0 00 00 00 00000000 0 1 1
00008082 0000103C 0 0 0 00 00 00 00000000 0 1 1

// ==== flist.f ====
+incdir+include
hdl/isa_pkg.sv
hdl/id_pkg.sv
hdl/rvc_expander.sv
hdl/instr_decoder.sv
hdl/issue_register.sv
hdl/id_stage.sv
test/id_stage_tb.sv

// ==== test/id_stage_tb.sv ====
// --------------------------------------------------
// Records come from test/id_testdata.txt, run from the project root
// --------------------------------------------------
`timescale 1ns/1ps

module id_stage_tb;

  localparam int HALF_PERIOD    = 2;
  localparam int RESET_CYCLES   = 4;
  localparam int NUM_REC        = 20;
  localparam int NUM_FIELDS     = 12;
  localparam int TIMEOUT_CYCLES = 400;
  localparam DATA_FILE          = "test/id_testdata.txt";

  // Column positions inside one record
  localparam int F_INSTR   = 0;
  localparam int F_PC      = 1;
  localparam int F_FLUSH   = 2;
  localparam int F_FU      = 3;
  localparam int F_FUNCT3  = 4;
  localparam int F_RD      = 5;
  localparam int F_RS1     = 6;
  localparam int F_RS2     = 7;
  localparam int F_IMM     = 8;
  localparam int F_CTRL    = 9;
  localparam int F_ILLEGAL = 10;
  localparam int F_COMP    = 11;

  // DUT inputs
  logic        clk_i;
  logic        rst_ni;
  logic        flush_i;
  logic [31:0] fetch_instr_i;
  logic [31:0] fetch_pc_i;
  logic        fetch_valid_i;
  logic        issue_ack_i;
  // DUT outputs
  logic        fetch_ready_o;
  logic        issue_valid_o;
  logic [31:0] issue_pc_o;
  logic [31:0] issue_orig_instr_o;
  logic [2:0]  issue_fu_o;
  logic [2:0]  issue_funct3_o;
  logic [4:0]  issue_rd_o;
  logic [4:0]  issue_rs1_o;
  logic [4:0]  issue_rs2_o;
  logic [31:0] issue_imm_o;
  logic        issue_is_ctrl_flow_o;
  logic        issue_illegal_o;
  logic        issue_is_compressed_o;

  // Flat record memory, NUM_FIELDS words per record
  logic [31:0] tdata [0:NUM_REC*NUM_FIELDS-1];

  int unsigned lcg_state;
  int          check_count;
  int          error_count;
  int          timeout_count;
  int          load_errors;
  int          delivered;
  // Records accepted but not yet acked or flushed, oldest first
  int          expect_q [$];
  // Non-flush records in file order for the streaming run
  int          stream_q [$];

  id_stage uut (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .fetch_instr_i         (fetch_instr_i),
    .fetch_pc_i            (fetch_pc_i),
    .fetch_valid_i         (fetch_valid_i),
    .fetch_ready_o         (fetch_ready_o),
    .issue_ack_i           (issue_ack_i),
    .issue_valid_o         (issue_valid_o),
    .issue_pc_o            (issue_pc_o),
    .issue_orig_instr_o    (issue_orig_instr_o),
    .issue_fu_o            (issue_fu_o),
    .issue_funct3_o        (issue_funct3_o),
    .issue_rd_o            (issue_rd_o),
    .issue_rs1_o           (issue_rs1_o),
    .issue_rs2_o           (issue_rs2_o),
    .issue_imm_o           (issue_imm_o),
    .issue_is_ctrl_flow_o  (issue_is_ctrl_flow_o),
    .issue_illegal_o       (issue_illegal_o),
    .issue_is_compressed_o (issue_is_compressed_o)
  );

  always #HALF_PERIOD clk_i = ~clk_i;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] field(input int rec, input int col);
    return tdata[rec*NUM_FIELDS + col];
  endfunction

  // Numerical Recipes LCG constants
  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR @ %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // Whole entry against the record's expected columns
  task automatic check_entry(input int rec);
    string tag;
    tag = $sformatf("rec %0d ", rec);
    compare_value({tag, "pc"}, issue_pc_o, field(rec, F_PC));
    compare_value({tag, "orig_instr"}, issue_orig_instr_o, field(rec, F_INSTR));
    compare_value({tag, "fu"}, issue_fu_o, field(rec, F_FU));
    compare_value({tag, "funct3"}, issue_funct3_o, field(rec, F_FUNCT3));
    compare_value({tag, "rd"}, issue_rd_o, field(rec, F_RD));
    compare_value({tag, "rs1"}, issue_rs1_o, field(rec, F_RS1));
    compare_value({tag, "rs2"}, issue_rs2_o, field(rec, F_RS2));
    compare_value({tag, "imm"}, issue_imm_o, field(rec, F_IMM));
    compare_value({tag, "ctrl_flow"}, issue_is_ctrl_flow_o, field(rec, F_CTRL));
    compare_value({tag, "illegal"}, issue_illegal_o, field(rec, F_ILLEGAL));
    compare_value({tag, "compressed"}, issue_is_compressed_o, field(rec, F_COMP));
  endtask

  task automatic drive_record(input int rec);
    fetch_instr_i = field(rec, F_INSTR);
    fetch_pc_i    = field(rec, F_PC);
    fetch_valid_i = 1'b1;
  endtask

  task automatic drive_idle();
    fetch_instr_i = '0;
    fetch_pc_i    = '0;
    fetch_valid_i = 1'b0;
  endtask

  // --------------------------------------------------
  // Random ack delay, flush on flagged records
  // --------------------------------------------------
  task automatic run_backpressure();
    int  send_idx;
    int  cycles;
    int  hold;
    int  front;
    int  expected_total;
    int  i;
    bit  seen;
    bit  model_full;
    bit  flushed_last;
    bit  do_ack;
    bit  do_flush;
    bit  accept;
    send_idx       = 0;
    cycles         = 0;
    hold           = 0;
    seen           = 1'b0;
    model_full     = 1'b0;
    flushed_last   = 1'b0;
    expected_total = 0;
    expect_q.delete();
    for (i = 0; i < NUM_REC; i++) begin
      if (field(i, F_FLUSH) == 0) expected_total++;
    end

    while ((send_idx < NUM_REC || expect_q.size() != 0) && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
      if (flushed_last) begin
        compare_value("issue_valid_o after flush", issue_valid_o, model_full);
      end else begin
        compare_value("issue_valid_o", issue_valid_o, model_full);
      end
      flushed_last = 1'b0;
      do_ack       = 1'b0;
      do_flush     = 1'b0;
      if (model_full) begin
        front = expect_q[0];
        // Held entry must match on every cycle until it leaves
        check_entry(front);
        if (!seen) begin
          hold = (next_random() >> 16) % 4;
          seen = 1'b1;
        end
        if (field(front, F_FLUSH) != 0) begin
          do_flush = 1'b1;
        end else if (hold == 0) begin
          do_ack = 1'b1;
        end else begin
          hold--;
        end
      end
      if (send_idx < NUM_REC) drive_record(send_idx);
      else drive_idle();
      issue_ack_i = do_ack;
      flush_i     = do_flush;
      #1;
      // Ready only with room, or with the held entry leaving now
      accept = (send_idx < NUM_REC) && (!model_full || do_ack);
      compare_value("fetch_ready_o", fetch_ready_o, accept);
      if (do_ack) begin
        void'(expect_q.pop_front());
        // Only a hand-over the DUT really offered counts
        if (issue_valid_o) delivered++;
        seen = 1'b0;
      end
      if (do_flush) begin
        void'(expect_q.pop_front());
        seen         = 1'b0;
        flushed_last = 1'b1;
      end
      // Advance on the fetch handshake the DUT actually made
      if (fetch_valid_i && fetch_ready_o) begin
        expect_q.push_back(send_idx);
        send_idx++;
      end
      model_full = (expect_q.size() != 0);
    end

    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: entries still pending after %0d cycles of the ack-delay run", cycles);
      timeout_count++;
    end
    @(negedge clk_i);
    drive_idle();
    issue_ack_i = 1'b0;
    flush_i     = 1'b0;
    compare_value("issue_valid_o after drain", issue_valid_o, 1'b0);
    compare_value("delivered entries", delivered, expected_total);
  endtask

  // --------------------------------------------------
  // One entry per cycle with ack held high
  // --------------------------------------------------
  task automatic run_throughput();
    int i;
    int k;
    stream_q.delete();
    for (i = 0; i < NUM_REC; i++) begin
      if (field(i, F_FLUSH) == 0) stream_q.push_back(i);
    end
    issue_ack_i = 1'b1;
    for (k = 0; k < stream_q.size(); k++) begin
      drive_record(stream_q[k]);
      #1;
      compare_value("fetch_ready_o while streaming", fetch_ready_o, 1'b1);
      @(negedge clk_i);
      // Accepted at the last edge, presented now
      compare_value("issue_valid_o while streaming", issue_valid_o, 1'b1);
      check_entry(stream_q[k]);
    end
    drive_idle();
    @(negedge clk_i);
    compare_value("issue_valid_o after stream", issue_valid_o, 1'b0);
    issue_ack_i = 1'b0;
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    issue_ack_i   = 1'b0;
    lcg_state     = 4;
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    load_errors   = 0;
    delivered     = 0;
    drive_idle();

    $readmemh(DATA_FILE, tdata);
    if ($isunknown(tdata[0]) || $isunknown(tdata[NUM_REC*NUM_FIELDS-1])) begin
      $display("Could not read %s, or it holds fewer than %0d records", DATA_FILE, NUM_REC);
      load_errors++;
    end

    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    compare_value("issue_valid_o in reset", issue_valid_o, 1'b0);
    compare_value("fetch_ready_o in reset", fetch_ready_o, 1'b0);
    rst_ni = 1'b1;
    @(negedge clk_i);
    compare_value("issue_valid_o after reset", issue_valid_o, 1'b0);
    compare_value("fetch_ready_o after reset", fetch_ready_o, 1'b0);

    if (load_errors == 0) begin
      run_backpressure();
      run_throughput();
    end

    $display("Checks: %0d, mismatches: %0d, timeouts: %0d, load errors: %0d",
             check_count, error_count, timeout_count, load_errors);
    if (error_count == 0 && timeout_count == 0 && load_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== hdl/id_stage.sv ====
// --------------------------------------------------
// Decode stage top, single issue port
// One cycle from fetch accept to issue valid
// --------------------------------------------------
`timescale 1ns/1ps

module id_stage (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  // Fetch handshake
  input  isa_pkg::instr_t    fetch_instr_i,
  input  id_pkg::addr_t      fetch_pc_i,
  input  logic               fetch_valid_i,
  output logic               fetch_ready_o,
  // Issue handshake
  input  logic               issue_ack_i,
  output logic               issue_valid_o,
  // Issue entry
  output id_pkg::addr_t      issue_pc_o,
  output isa_pkg::instr_t    issue_orig_instr_o,
  output id_pkg::fu_t        issue_fu_o,
  output id_pkg::funct3_t    issue_funct3_o,
  output isa_pkg::reg_addr_t issue_rd_o,
  output isa_pkg::reg_addr_t issue_rs1_o,
  output isa_pkg::reg_addr_t issue_rs2_o,
  output id_pkg::imm_t       issue_imm_o,
  output logic               issue_is_ctrl_flow_o,
  output logic               issue_illegal_o,
  output logic               issue_is_compressed_o
);

  import isa_pkg::*;
  import id_pkg::*;

  // Expander outputs
  instr_t    exp_instr;
  logic      exp_compressed;
  logic      exp_illegal;

  // Decoder outputs
  fu_t       dec_fu;
  funct3_t   dec_funct3;
  reg_addr_t dec_rd;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  imm_t      dec_imm;
  logic      dec_ctrl_flow;
  logic      dec_illegal;

  // Either stage may reject the word
  logic      entry_illegal;

  // --------------------------------------------------
  // Expand, then decode
  // --------------------------------------------------
  rvc_expander i_rvc_expander (
    .instr_i         (fetch_instr_i),
    .instr_o         (exp_instr),
    .is_compressed_o (exp_compressed),
    .illegal_o       (exp_illegal)
  );

  instr_decoder i_instr_decoder (
    .instr_i        (exp_instr),
    .fu_o           (dec_fu),
    .funct3_o       (dec_funct3),
    .rd_o           (dec_rd),
    .rs1_o          (dec_rs1),
    .rs2_o          (dec_rs2),
    .imm_o          (dec_imm),
    .is_ctrl_flow_o (dec_ctrl_flow),
    .illegal_o      (dec_illegal)
  );

  assign entry_illegal = exp_illegal | dec_illegal;

  // --------------------------------------------------
  // ID/issue register
  // --------------------------------------------------
  // Original fetched word is kept, not the expansion
  issue_register i_issue_register (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_ready_o   (fetch_ready_o),
    .issue_ack_i     (issue_ack_i),
    .issue_valid_o   (issue_valid_o),
    .pc_i            (fetch_pc_i),
    .orig_instr_i    (fetch_instr_i),
    .fu_i            (dec_fu),
    .funct3_i        (dec_funct3),
    .rd_i            (dec_rd),
    .rs1_i           (dec_rs1),
    .rs2_i           (dec_rs2),
    .imm_i           (dec_imm),
    .is_ctrl_flow_i  (dec_ctrl_flow),
    .illegal_i       (entry_illegal),
    .is_compressed_i (exp_compressed),
    .pc_o            (issue_pc_o),
    .orig_instr_o    (issue_orig_instr_o),
    .fu_o            (issue_fu_o),
    .funct3_o        (issue_funct3_o),
    .rd_o            (issue_rd_o),
    .rs1_o           (issue_rs1_o),
    .rs2_o           (issue_rs2_o),
    .imm_o           (issue_imm_o),
    .is_ctrl_flow_o  (issue_is_ctrl_flow_o),
    .illegal_o       (issue_illegal_o),
    .is_compressed_o (issue_is_compressed_o)
  );

endmodule

// ==== hdl/issue_register.sv ====
// --------------------------------------------------
// Single-entry ID/issue register
// Fetch and issue can hand over in the same cycle
// --------------------------------------------------
`timescale 1ns/1ps

module issue_register (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  // Fetch side
  input  logic               fetch_valid_i,
  output logic               fetch_ready_o,
  // Issue side
  input  logic               issue_ack_i,
  output logic               issue_valid_o,
  // Entry fields in from decode
  input  id_pkg::addr_t      pc_i,
  input  isa_pkg::instr_t    orig_instr_i,
  input  id_pkg::fu_t        fu_i,
  input  id_pkg::funct3_t    funct3_i,
  input  isa_pkg::reg_addr_t rd_i,
  input  isa_pkg::reg_addr_t rs1_i,
  input  isa_pkg::reg_addr_t rs2_i,
  input  id_pkg::imm_t       imm_i,
  input  logic               is_ctrl_flow_i,
  input  logic               illegal_i,
  input  logic               is_compressed_i,
  // Registered entry out to issue
  output id_pkg::addr_t      pc_o,
  output isa_pkg::instr_t    orig_instr_o,
  output id_pkg::fu_t        fu_o,
  output id_pkg::funct3_t    funct3_o,
  output isa_pkg::reg_addr_t rd_o,
  output isa_pkg::reg_addr_t rs1_o,
  output isa_pkg::reg_addr_t rs2_o,
  output id_pkg::imm_t       imm_o,
  output logic               is_ctrl_flow_o,
  output logic               illegal_o,
  output logic               is_compressed_o
);

  logic valid_q;
  logic valid_d;
  logic accept;

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------
  // Room when empty or when the held entry leaves this cycle
  assign fetch_ready_o = fetch_valid_i & (~valid_q | issue_ack_i);
  assign accept        = fetch_ready_o;
  assign issue_valid_o = valid_q;

  // Flush wins over a new word, the word is taken and dropped
  always_comb begin
    valid_d = valid_q;
    if (issue_ack_i) begin
      valid_d = 1'b0;
    end
    if (accept) begin
      valid_d = 1'b1;
    end
    if (flush_i) begin
      valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // --------------------------------------------------
  // Payload
  // --------------------------------------------------
  // Loaded only on accept, so it holds while issue stalls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pc_o            <= pc_i;
      orig_instr_o    <= orig_instr_i;
      fu_o            <= fu_i;
      funct3_o        <= funct3_i;
      rd_o            <= rd_i;
      rs1_o           <= rs1_i;
      rs2_o           <= rs2_i;
      imm_o           <= imm_i;
      is_ctrl_flow_o  <= is_ctrl_flow_i;
      illegal_o       <= illegal_i;
      is_compressed_o <= is_compressed_i;
    end
  end

  // Never ready toward an idle fetch
  ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_ready_o |-> fetch_valid_i);

  // Nothing survives a flush into the next cycle
  flush_empties: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !issue_valid_o);

endmodule

// ==== hdl/instr_decoder.sv ====
// --------------------------------------------------
// Decodes by major opcode only
// funct7 and funct3 values are not checked for legality
// --------------------------------------------------
`timescale 1ns/1ps
`include "id_consts.svh"

module instr_decoder (
  input  isa_pkg::instr_t    instr_i,
  output id_pkg::fu_t        fu_o,
  output id_pkg::funct3_t    funct3_o,
  output isa_pkg::reg_addr_t rd_o,
  output isa_pkg::reg_addr_t rs1_o,
  output isa_pkg::reg_addr_t rs2_o,
  output id_pkg::imm_t       imm_o,
  output logic               is_ctrl_flow_o,
  output logic               illegal_o
);

  import isa_pkg::*;
  import id_pkg::*;

  // --------------------------------------------------
  // Raw fields at their standard positions
  // --------------------------------------------------
  logic [6:0] opcode;
  funct3_t    f3;
  reg_addr_t  rd;
  reg_addr_t  rs1;
  reg_addr_t  rs2;

  assign opcode = instr_i[6:0];
  assign f3     = instr_i[14:12];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];

  // --------------------------------------------------
  // Immediate formats, all sign extended from bit 31
  // --------------------------------------------------
  imm_t imm_i_type;
  imm_t imm_s_type;
  imm_t imm_b_type;
  imm_t imm_u_type;
  imm_t imm_j_type;

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  // Branch offsets are halfword aligned
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                       instr_i[20], instr_i[30:21], 1'b0};

  // --------------------------------------------------
  // Opcode decode
  // --------------------------------------------------
  // Fields a format does not carry stay zero
  always_comb begin
    fu_o      = `FU_NONE;
    funct3_o  = '0;
    rd_o      = '0;
    rs1_o     = '0;
    rs2_o     = '0;
    imm_o     = '0;
    illegal_o = 1'b0;

    case (opcode)
      `OPC_OP_IMM: begin
        fu_o     = `FU_ALU;
        funct3_o = f3;
        rd_o     = rd;
        rs1_o    = rs1;
        imm_o    = imm_i_type;
      end
      // Register-register ALU op, no immediate
      `OPC_OP: begin
        fu_o     = `FU_ALU;
        funct3_o = f3;
        rd_o     = rd;
        rs1_o    = rs1;
        rs2_o    = rs2;
      end
      // Bits [14:12] belong to the immediate, funct3 stays zero
      `OPC_LUI: begin
        fu_o  = `FU_ALU;
        rd_o  = rd;
        imm_o = imm_u_type;
      end
      // Same for JAL
      `OPC_JAL: begin
        fu_o  = `FU_CTRL_FLOW;
        rd_o  = rd;
        imm_o = imm_j_type;
      end
      `OPC_JALR: begin
        fu_o     = `FU_CTRL_FLOW;
        funct3_o = f3;
        rd_o     = rd;
        rs1_o    = rs1;
        imm_o    = imm_i_type;
      end
      // Compare two sources, writes nothing
      `OPC_BRANCH: begin
        fu_o     = `FU_CTRL_FLOW;
        funct3_o = f3;
        rs1_o    = rs1;
        rs2_o    = rs2;
        imm_o    = imm_b_type;
      end
      `OPC_LOAD: begin
        fu_o     = `FU_LOAD;
        funct3_o = f3;
        rd_o     = rd;
        rs1_o    = rs1;
        imm_o    = imm_i_type;
      end
      `OPC_STORE: begin
        fu_o     = `FU_STORE;
        funct3_o = f3;
        rs1_o    = rs1;
        rs2_o    = rs2;
        imm_o    = imm_s_type;
      end
      // Unknown group, everything zero
      default: illegal_o = 1'b1;
    endcase
  end

  // Jumps and branches go to the control-flow unit
  assign is_ctrl_flow_o = (fu_o == `FU_CTRL_FLOW);

endmodule

// ==== hdl/rvc_expander.sv ====
// --------------------------------------------------
// Expands C.ADDI, C.LI, C.MV, C.ADD, C.J, C.LW, C.SW
// Every other compressed pattern is flagged illegal
// --------------------------------------------------
`timescale 1ns/1ps
`include "id_consts.svh"

module rvc_expander (
  input  isa_pkg::instr_t instr_i,
  output isa_pkg::instr_t instr_o,
  output logic            is_compressed_o,
  output logic            illegal_o
);

  import isa_pkg::*;

  // --------------------------------------------------
  // Field extraction from the low halfword
  // --------------------------------------------------
  // Compressed funct3 sits in [15:13]
  logic [2:0]  c_funct3;
  // Full rd/rs1 at [11:7] and rs2 at [6:2] (CR/CI formats)
  reg_addr_t   rd_full;
  reg_addr_t   rs2_full;
  // Short registers of the CL/CS formats
  creg_t       rdp;
  creg_t       rs1p;
  reg_addr_t   rdp_x;
  reg_addr_t   rs1p_x;
  // Immediates widened to the 12 bits of an I/S field
  logic [11:0] imm6_sx;
  logic [11:0] uimm_w;
  // C.J offset, bit 0 is always zero
  logic [11:0] j_off;

  assign c_funct3 = instr_i[15:13];
  assign rd_full  = instr_i[11:7];
  assign rs2_full = instr_i[6:2];
  assign rdp      = instr_i[4:2];
  assign rs1p     = instr_i[9:7];

  // x8 + short index
  assign rdp_x  = {2'b01, rdp};
  assign rs1p_x = {2'b01, rs1p};

  // CI immediate {[12], [6:2]}, sign extended
  assign imm6_sx = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};

  // Word offset of C.LW/C.SW
  // uimm[6]=[5], uimm[5:3]=[12:10], uimm[2]=[6]
  assign uimm_w = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00};

  // CJ offset bits [11|4|9:8|10|6|7|3:1|5] live in [12:2]
  assign j_off = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
                  instr_i[7], instr_i[2], instr_i[11], instr_i[5:3], 1'b0};

  // --------------------------------------------------
  // Expansion
  // --------------------------------------------------
  always_comb begin
    instr_o         = '0;
    is_compressed_o = 1'b1;
    illegal_o       = 1'b0;

    case (instr_i[1:0])
      // Loads and stores on x8..x15
      `RVC_Q0: begin
        case (c_funct3)
          3'b010: begin
            // C.LW -> lw rd', uimm(rs1')
            instr_o = {uimm_w, rs1p_x, 3'b010, rdp_x, `OPC_LOAD};
          end
          3'b110: begin
            // C.SW -> sw rs2', uimm(rs1')
            instr_o = {uimm_w[11:5], rdp_x, rs1p_x, 3'b010, uimm_w[4:0], `OPC_STORE};
          end
          // Includes the all-zero halfword (C.ADDI4SPN slot)
          default: illegal_o = 1'b1;
        endcase
      end

      // Immediate arithmetic and jumps
      `RVC_Q1: begin
        case (c_funct3)
          3'b000: begin
            // C.ADDI -> addi rd, rd, imm
            instr_o = {imm6_sx, rd_full, 3'b000, rd_full, `OPC_OP_IMM};
          end
          3'b010: begin
            // C.LI -> addi rd, x0, imm
            instr_o = {imm6_sx, 5'd0, 3'b000, rd_full, `OPC_OP_IMM};
          end
          3'b101: begin
            // C.J -> jal x0, offset
            // J-type scatter with the sign copied into [20] and [19:12]
            instr_o = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}},
                       5'd0, `OPC_JAL};
          end
          default: illegal_o = 1'b1;
        endcase
      end

      // Register moves and adds
      `RVC_Q2: begin
        // rs2 == 0 here would be C.JR/C.JALR/C.EBREAK, not handled
        if (c_funct3 == 3'b100 && rs2_full != 5'd0) begin
          if (instr_i[12]) begin
            // C.ADD -> add rd, rd, rs2
            instr_o = {7'b0, rs2_full, rd_full, 3'b000, rd_full, `OPC_OP};
          end else begin
            // C.MV -> add rd, x0, rs2
            instr_o = {7'b0, rs2_full, 5'd0, 3'b000, rd_full, `OPC_OP};
          end
        end else begin
          illegal_o = 1'b1;
        end
      end

      // Full 32-bit word, untouched
      default: begin
        instr_o         = instr_i;
        is_compressed_o = 1'b0;
      end
    endcase
  end

  // Illegal can only come out of a compressed quadrant
  illegal_only_compressed: assert final (!illegal_o || is_compressed_o)
    else $error("rvc_expander: illegal flagged on a 32-bit word");

endmodule

// ==== hdl/id_pkg.sv ====
// --------------------------------------------------
// Types of the decoded issue entry
// --------------------------------------------------
`include "id_consts.svh"

package id_pkg;

  // --------------------------------------------------
  // Address and data
  // --------------------------------------------------
  // Program counter of the fetched word
  typedef logic [`ID_XLEN-1:0] addr_t;

  // Immediate, already sign extended to XLEN
  typedef logic [`ID_XLEN-1:0] imm_t;

  // --------------------------------------------------
  // Operation selection
  // --------------------------------------------------
  // Holds one of the FU_* codes
  typedef logic [`ID_FU_W-1:0] fu_t;

  // Sub-operation as encoded in bits [14:12]
  typedef logic [`ID_FUNCT3_W-1:0] funct3_t;

endpackage

// ==== hdl/isa_pkg.sv ====
// --------------------------------------------------
// Types of the raw RISC-V instruction encoding
// --------------------------------------------------
`include "id_consts.svh"

package isa_pkg;

  // --------------------------------------------------
  // Instruction words
  // --------------------------------------------------
  // A full 32-bit word, also carries a compressed halfword in [15:0]
  typedef logic [`ID_ILEN-1:0] instr_t;

  // --------------------------------------------------
  // Register fields
  // --------------------------------------------------
  // Short form used by C.LW/C.SW
  // Maps onto x8..x15
  typedef logic [`ID_CREG_W-1:0] creg_t;

  // Full register index as found at rd/rs1/rs2
  typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

endpackage

// ==== include/id_consts.svh ====
// --------------------------------------------------
// Shared constants of the RV32 decode stage
// Only the RV32I and RVC subsets decoded here are covered
// --------------------------------------------------
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

// --------------------------------------------------
// Widths
// --------------------------------------------------
// Data and address width
`define ID_XLEN 32
// Instruction word width after expansion
`define ID_ILEN 32
// Architectural register index
`define ID_REG_ADDR_W 5
// Register field of the compressed formats (x8..x15)
`define ID_CREG_W 3
// Functional-unit code and operation selector
`define ID_FU_W 3
`define ID_FUNCT3_W 3

// --------------------------------------------------
// Major opcodes, bits [6:0]
// --------------------------------------------------
`define OPC_OP_IMM 7'b0010011
`define OPC_OP 7'b0110011
`define OPC_LUI 7'b0110111
`define OPC_JAL 7'b1101111
`define OPC_JALR 7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD 7'b0000011
`define OPC_STORE 7'b0100011

// --------------------------------------------------
// Functional-unit codes
// --------------------------------------------------
`define FU_NONE 3'd0
`define FU_ALU 3'd1
`define FU_CTRL_FLOW 3'd2
`define FU_LOAD 3'd3
`define FU_STORE 3'd4

// Compressed quadrants, bits [1:0]; 2'b11 marks a full word
`define RVC_Q0 2'b00
`define RVC_Q1 2'b01
`define RVC_Q2 2'b10

`endif
